//--- design/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // 24C16: 2K bytes, block bits go in the select byte
    typedef logic [10:0] eeprom_addr_t;
    typedef logic [7:0]  eeprom_byte_t;

    // bit engine commands
    // start while the bus is owned gives a repeated start
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_cmd_t;

    localparam logic [3:0] DEVICE_CODE = 4'b1010; // serial eeprom type code

endpackage

`default_nettype wire

//--- design/i2c_bit_engine.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_engine import eeprom_pkg::*; #(
    parameter int CLK_DIV = 2
) (
    input  logic         CLK,
    input  logic         RESET,
    input  i2c_cmd_t     cmd,
    input  logic         cmd_valid,
    input  eeprom_byte_t tx_byte,
    input  logic         tx_ack,
    output logic         done,
    output eeprom_byte_t rx_byte,
    output logic         rx_ack,
    output logic         scl,
    output logic         sda_oe,
    input  wire          sda_in
);

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PH0,
        ST_PH1,
        ST_PH2,
        ST_PH3
    } state_t;

    state_t        state;
    state_t        state_next;
    i2c_cmd_t      cmd_q;
    logic [QW-1:0] qcnt;
    logic [3:0]    bit_cnt;
    logic [3:0]    bit_next;
    logic [1:0]    ph_next;
    logic          tx_next;
    logic          nack_q;
    eeprom_byte_t  shreg;
    logic          qtick;
    logic          last_bit;
    logic [1:0]    lvl_start;
    logic [1:0]    lvl_next;

    // returns {scl, pull sda low} for a given phase of a bit
    function automatic logic [1:0] bus_level(
        input i2c_cmd_t   c,
        input logic [3:0] b,
        input logic [1:0] ph,
        input logic       tx_bit,
        input logic       nack,
        input logic       cur_scl
    );
        logic clk_hi;
        logic pull;
        clk_hi = (ph == 2'd1) || (ph == 2'd2);
        case (c)
            CMD_START: begin
                // phase 0 keeps scl, so idle and repeated start share one path
                clk_hi = (ph == 2'd0) ? cur_scl : (ph != 2'd3);
                pull   = ph[1];         // sda falls with scl high
            end
            CMD_STOP: begin
                clk_hi = (ph != 2'd0);
                pull   = !ph[1];        // sda rises with scl high
            end
            CMD_WRITE: pull = (b == 4'd8) ? 1'b0 : !tx_bit; // release for slave ack
            default:   pull = (b == 4'd8) ? !nack : 1'b0;   // master ack after read
        endcase
        return {clk_hi, pull};
    endfunction

    assign qtick    = (state != ST_IDLE) && (qcnt == QW'(CLK_DIV - 1));
    assign last_bit = !((cmd_q == CMD_WRITE) || (cmd_q == CMD_READ)) || (bit_cnt == 4'd8);
    assign done     = qtick && (state == ST_PH3) && last_bit;

    assign lvl_start = bus_level(cmd, 4'd0, 2'd0, tx_byte[7], tx_ack, scl);

    always_comb begin
        ph_next    = 2'd0;
        state_next = ST_PH0;
        bit_next   = bit_cnt;
        tx_next    = shreg[7];
        case (state)
            ST_PH0: begin
                ph_next    = 2'd1;
                state_next = ST_PH1;
            end
            ST_PH1: begin
                ph_next    = 2'd2;
                state_next = ST_PH2;
            end
            ST_PH2: begin
                ph_next    = 2'd3;
                state_next = ST_PH3;
            end
            default: begin
                // wrap into the next bit
                bit_next = bit_cnt + 4'd1;
                tx_next  = shreg[6];
            end
        endcase
        lvl_next = bus_level(cmd_q, bit_next, ph_next, tx_next, nack_q, scl);
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= ST_IDLE;
            cmd_q   <= CMD_STOP;
            qcnt    <= '0;
            bit_cnt <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end else if (state == ST_IDLE) begin
            if (cmd_valid) begin
                state   <= ST_PH0;
                cmd_q   <= cmd;
                qcnt    <= '0;
                bit_cnt <= '0;
                {scl, sda_oe} <= lvl_start;
            end
        end else if (qtick) begin
            qcnt <= '0;
            if (done) begin
                state <= ST_IDLE; // bus levels hold until next command
            end else begin
                state   <= state_next;
                bit_cnt <= bit_next;
                {scl, sda_oe} <= lvl_next;
            end
        end else begin
            qcnt <= qcnt + 1'b1;
        end
    end

    // shift and sample path
    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && cmd_valid) begin
            shreg  <= tx_byte;
            nack_q <= tx_ack;
        end else if (qtick) begin
            if (state == ST_PH3) begin
                shreg <= {shreg[6:0], 1'b0}; // msb first
            end
            // end of phase 1 is the middle of scl high
            if (state == ST_PH1) begin
                if (cmd_q == CMD_WRITE && bit_cnt == 4'd8) begin
                    rx_ack <= sda_in;
                end
                if (cmd_q == CMD_READ && bit_cnt < 4'd8) begin
                    rx_byte <= {rx_byte[6:0], sda_in};
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/eeprom_seq.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_seq import eeprom_pkg::*; (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wr,
    input  logic         rd,
    input  eeprom_addr_t addr,
    input  eeprom_byte_t wr_data,
    output eeprom_byte_t rd_data,
    output logic         ack,
    output logic         ack_err,
    output logic         busy,
    output i2c_cmd_t     cmd,
    output logic         cmd_valid,
    output eeprom_byte_t tx_byte,
    output logic         tx_ack,
    input  logic         done,
    input  eeprom_byte_t rx_byte,
    input  logic         rx_ack
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_SEL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RESTART,
        S_SEL_RD,
        S_DATA_RD,
        S_STOP,
        S_FINISH
    } state_t;

    state_t       state;
    state_t       state_nxt;
    eeprom_addr_t addr_q;
    eeprom_byte_t data_q;
    logic         rd_q;
    logic         accept;
    logic         byte_nak;

    // finish is the ack cycle, busy already low there
    assign busy   = (state != S_IDLE) && (state != S_FINISH);
    assign ack    = (state == S_FINISH);
    assign accept = !busy && (wr || rd);

    // slave did not acknowledge a byte we sent
    assign byte_nak = rx_ack && (state inside {S_SEL_WR, S_ADDR, S_DATA_WR, S_SEL_RD});

    always_comb begin
        case (state)
            S_START, S_RESTART: cmd = CMD_START;
            S_STOP:             cmd = CMD_STOP;
            S_DATA_RD:          cmd = CMD_READ;
            default:            cmd = CMD_WRITE;
        endcase
    end

    always_comb begin
        case (state)
            S_SEL_WR: tx_byte = {DEVICE_CODE, addr_q[10:8], 1'b0};
            S_SEL_RD: tx_byte = {DEVICE_CODE, addr_q[10:8], 1'b1};
            S_ADDR:   tx_byte = addr_q[7:0];
            default:  tx_byte = data_q;
        endcase
    end

    assign tx_ack = (state == S_DATA_RD); // single byte read always ends with nack

    always_comb begin
        case (state)
            S_START:   state_nxt = S_SEL_WR;
            S_SEL_WR:  state_nxt = S_ADDR;
            S_ADDR:    state_nxt = rd_q ? S_RESTART : S_DATA_WR;
            S_RESTART: state_nxt = S_SEL_RD;
            S_SEL_RD:  state_nxt = S_DATA_RD;
            S_DATA_WR: state_nxt = S_STOP;
            S_DATA_RD: state_nxt = S_STOP;
            S_STOP:    state_nxt = S_FINISH;
            default:   state_nxt = S_IDLE;
        endcase
        if (byte_nak) begin
            state_nxt = S_STOP; // skip the rest of the transfer
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= S_IDLE;
            cmd_valid <= 1'b0;
            ack_err   <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (accept) begin
                state     <= S_START;
                cmd_valid <= 1'b1;
                ack_err   <= 1'b0;
            end else if (done && busy) begin
                state     <= state_nxt;
                cmd_valid <= (state_nxt != S_FINISH);
                if (byte_nak) begin
                    ack_err <= 1'b1;
                end
            end else if (state == S_FINISH) begin
                state <= S_IDLE;
            end
        end
    end

    // request latch, write wins over read
    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q <= addr;
            data_q <= wr_data;
            rd_q   <= !wr;
        end
    end

    always_ff @(posedge CLK) begin
        if (done && state == S_DATA_RD) begin
            rd_data <= rx_byte; // held until next read completes
        end
    end

endmodule

`default_nettype wire

//--- design/eeprom_i2c_top.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_i2c_top import eeprom_pkg::*; #(
    parameter int CLK_DIV = 2
) (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wr,
    input  logic         rd,
    input  eeprom_addr_t addr,
    input  eeprom_byte_t wr_data,
    output eeprom_byte_t rd_data,
    output logic         ack,
    output logic         ack_err,
    output logic         busy,
    output logic         scl,
    inout  wire          sda
);

    i2c_cmd_t     cmd;
    logic         cmd_valid;
    eeprom_byte_t tx_byte;
    logic         tx_ack;
    logic         done;
    eeprom_byte_t rx_byte;
    logic         rx_ack;
    logic         sda_oe;

    // open drain, pullup sits on the board side
    assign sda = sda_oe ? 1'b0 : 1'bz;

    eeprom_seq u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .ack       (ack),
        .ack_err   (ack_err),
        .busy      (busy),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack),
        .done      (done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack),
        .done      (done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)        // bus level as seen on the wire
    );

endmodule

`default_nettype wire

//--- dv/eeprom_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_asserts (
    input wire CLK,
    input wire RESET,
    input wire ack,
    input wire busy,
    input wire scl,
    input wire sda
);

    int fails = 0;

    ack_pulse: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else begin
            fails++;
            $error("ack held for more than one cycle");
        end

    // ack ends a transfer, busy drops with it
    ack_busy_fall: assert property (@(posedge CLK) disable iff (RESET) ack |-> $fell(busy))
        else begin
            fails++;
            $error("busy did not fall together with ack");
        end

    // start and stop only inside a transfer
    sda_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda)) |-> busy)
        else begin
            fails++;
            $error("sda moved under high scl while idle");
        end

    idle_scl: assert property (@(posedge CLK) disable iff (RESET) !busy |-> scl)
        else begin
            fails++;
            $error("scl low while idle");
        end

endmodule

`default_nettype wire

//--- dv/eeprom_model.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_model import eeprom_pkg::*; (
    input  wire  scl,
    inout  wire  sda,
    input  logic ignore         // drop off the bus, never ack
);

    typedef enum {M_IDLE, M_SEL, M_WORD, M_DATA, M_READ, M_WAIT} mode_t;

    eeprom_byte_t mem [0:2047];
    mode_t        mode = M_IDLE;
    eeprom_byte_t sh;
    eeprom_byte_t word;
    logic [2:0]   blk;
    logic [3:0]   bit_cnt = 4'd0;
    logic         pull = 1'b0;

    assign sda = pull ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'hff;     // erased array
        end
    end

    // a received byte is complete, decide on the ack
    task automatic take_byte();
        pull = 1'b1;
        case (mode)
            M_SEL: begin
                if (ignore || sh[7:4] != DEVICE_CODE) begin
                    pull = 1'b0;
                    mode = M_WAIT;
                end else begin
                    blk  = sh[3:1];
                    mode = sh[0] ? M_READ : M_WORD;
                    if (sh[0]) begin
                        sh = mem[{blk, word}];
                    end
                end
            end
            M_WORD: begin
                word = sh;
                mode = M_DATA;
            end
            default: begin
                mem[{blk, word}] = sh;  // commits at once, no write cycle
                mode = M_WAIT;
            end
        endcase
    endtask

    always @(negedge sda) begin
        if (scl === 1'b1) begin
            mode    = M_SEL;    // start or repeated start
            bit_cnt = 4'd0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            mode = M_IDLE;
        end
    end

    always @(posedge scl) begin
        if (mode != M_IDLE) begin
            if (bit_cnt < 4'd8) begin
                sh      = {sh[6:0], (sda !== 1'b0)};
                bit_cnt = bit_cnt + 4'd1;
            end else begin
                if (mode == M_READ && sda !== 1'b0) begin
                    mode = M_WAIT;  // master nack ends the read
                end
                bit_cnt = 4'd9;
            end
        end
    end

    // sda only moves while scl is low
    always @(negedge scl) begin
        if (bit_cnt == 4'd9) begin
            bit_cnt = 4'd0;
            pull    = (mode == M_READ) && !sh[7];
        end else if (mode == M_READ) begin
            pull = (bit_cnt != 4'd8) && !sh[7];
        end else if (bit_cnt == 4'd8 && mode != M_IDLE && mode != M_WAIT) begin
            take_byte();
        end
    end

endmodule

`default_nettype wire

//--- dv/eeprom_checker.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_checker import eeprom_pkg::*; (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wr,
    input  logic         rd,
    input  eeprom_addr_t addr,
    input  eeprom_byte_t wr_data,
    input  eeprom_byte_t rd_data,
    input  logic         ack,
    input  logic         ack_err,
    input  logic         busy,
    input  logic         model_off,
    output int           checks,
    output int           errors
);

    eeprom_byte_t shadow [0:2047];
    eeprom_addr_t addr_q;
    eeprom_byte_t data_q;
    logic         wr_q;
    logic         off_q;
    logic         pending = 1'b0;
    logic [8:0]   expect_v;

    // {ack_err, byte} a transfer should end with
    function automatic logic [8:0] expected(input eeprom_addr_t a, input logic off);
        return {off, shadow[a]};    // absent slave never acks
    endfunction

    initial begin
        checks = 0;
        errors = 0;
        for (int i = 0; i < 2048; i++) begin
            shadow[i] = 8'hff;
        end
    end

    // sampled mid cycle between DUT and stimulus edges
    always @(negedge CLK) begin
        if (RESET) begin
            pending = 1'b0;
        end else begin
            if (ack && !pending) begin
                errors++;
                $display("ack came at %0t ns with no transfer open", $time);
            end else if (ack) begin
                expect_v = expected(addr_q, off_q);
                checks++;
                if (ack_err !== expect_v[8]) begin
                    errors++;
                    $display("error at %0t ns: ack_err expected %b, got %b",
                             $time, expect_v[8], ack_err);
                end
                if (!wr_q && !expect_v[8]) begin
                    checks++;
                    if (rd_data !== expect_v[7:0]) begin
                        errors++;
                        $display("error at %0t ns: rd_data expected %h, got %h",
                                 $time, expect_v[7:0], rd_data);
                    end
                end
                if (wr_q && !expect_v[8]) begin
                    shadow[addr_q] = data_q;
                end
                pending = 1'b0;
            end
            if (!busy && (wr || rd)) begin
                addr_q  = addr;
                data_q  = wr_data;
                wr_q    = wr;
                off_q   = model_off;
                pending = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_eeprom.sv
`timescale 1ns/100ps
`default_nettype none

module tb_eeprom import eeprom_pkg::*; ();

    localparam int CLK_DIV    = 2;
    localparam int N_TRANS    = 60;
    localparam int MAX_CYCLES = N_TRANS * 44 * 4 * CLK_DIV * 2; // 44 bit-times, 2x margin

    logic         CLK = 1'b0;
    logic         RESET = 1'b1;
    logic         wr = 1'b0;
    logic         rd = 1'b0;
    eeprom_addr_t addr = '0;
    eeprom_byte_t wr_data = '0;
    eeprom_byte_t rd_data;
    logic         ack;
    logic         ack_err;
    logic         busy;
    logic         scl;
    wire          sda;
    logic         model_off = 1'b0;
    logic [31:0]  rnd = 32'd19;
    eeprom_addr_t keep_a;
    int           n_trans = 0;
    int           cycles = 0;
    int           checks;
    int           errors;

    pullup (sda);

    always #20 CLK = !CLK;

    eeprom_i2c_top #(
        .CLK_DIV (CLK_DIV)
    ) eeprom_i2c_top_i (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .rd_data(rd_data), .ack(ack), .ack_err(ack_err), .busy(busy), .scl(scl), .sda(sda)
    );

    eeprom_model model_i (.scl(scl), .sda(sda), .ignore(model_off));

    eeprom_checker checker_i (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .rd_data(rd_data), .ack(ack), .ack_err(ack_err), .busy(busy),
        .model_off(model_off), .checks(checks), .errors(errors)
    );

    bind eeprom_i2c_top eeprom_asserts asserts_i (
        .CLK(CLK), .RESET(RESET), .ack(ack), .busy(busy), .scl(scl), .sda(sda)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // called 2 ns after a rising edge, returns likewise after ack
    task automatic transfer(input logic is_wr, input eeprom_addr_t a, input eeprom_byte_t d);
        wr      = is_wr;
        rd      = !is_wr;
        addr    = a;
        wr_data = d;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        rd = 1'b0;
        while (ack !== 1'b1) begin
            @(posedge CLK);
            #2;
        end
        n_trans++;
    endtask

    initial begin
        repeat (10) @(posedge CLK);
        #2;
        RESET = 1'b0;
        @(posedge CLK);
        #2;
        transfer(1'b0, 11'h5a5, 8'h00);     // erased cell
        transfer(1'b1, 11'h123, 8'ha7);
        transfer(1'b0, 11'h123, 8'h00);
        // one word address in all eight blocks
        rnd    = lcg(rnd);
        keep_a = {3'd0, rnd[23:16]};
        for (int b = 0; b < 8; b++) begin
            rnd = lcg(rnd);
            transfer(1'b1, {b[2:0], keep_a[7:0]}, rnd[31:24]);
        end
        for (int b = 0; b < 8; b++) begin
            transfer(1'b0, {b[2:0], keep_a[7:0]}, 8'h00);
        end
        transfer(1'b1, 11'h2f0, 8'h11);
        transfer(1'b1, 11'h2f0, 8'hee);
        transfer(1'b0, 11'h2f0, 8'h00);
        repeat (17) begin
            rnd = lcg(rnd);
            transfer(1'b1, rnd[26:16], rnd[31:24]);
            transfer(1'b0, rnd[26:16], 8'h00);
        end
        // slave gone, then back with contents intact
        model_off = 1'b1;
        transfer(1'b1, 11'h2f0, 8'h11);
        transfer(1'b0, 11'h123, 8'h00);
        model_off = 1'b0;
        transfer(1'b0, {3'd4, keep_a[7:0]}, 8'h00);
        transfer(1'b0, 11'h2f0, 8'h00);
        repeat (4) @(posedge CLK);
        $display("transfers %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_trans, checks, errors, eeprom_i2c_top_i.asserts_i.fails);
        if (errors == 0 && eeprom_i2c_top_i.asserts_i.fails == 0 && checks > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("run hung, no end after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_seq.sv
design/eeprom_i2c_top.sv
dv/eeprom_asserts.sv
dv/eeprom_model.sv
dv/eeprom_checker.sv
dv/tb_eeprom.sv

//--- Bender.yml
package:
  name: eeprom_i2c

sources:
  - design/eeprom_pkg.sv
  - design/i2c_bit_engine.sv
  - design/eeprom_seq.sv
  - design/eeprom_i2c_top.sv
  - target: test
    files:
      - dv/eeprom_asserts.sv
      - dv/eeprom_model.sv
      - dv/eeprom_checker.sv
      - dv/tb_eeprom.sv
